/* hw/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int MEM_ADDR_W = 10;
    localparam int ALU_OP_W   = 4;

    localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND    = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR     = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR    = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLT    = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SLL    = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRL    = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 4'd8;

    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    localparam logic [1:0] WB_ALU = 2'd0;
    localparam logic [1:0] WB_MEM = 2'd1;
    localparam logic [1:0] WB_PC4 = 2'd2;

    // Both I/O registers sit just above the 4 KB array, reachable with lui x?, 1.
    localparam logic [DATA_W-1:0] SW_ADDR  = 32'h0000_1000;
    localparam logic [DATA_W-1:0] LED_ADDR = 32'h0000_1004;

    // addi x0, x0, 0
    localparam logic [DATA_W-1:0] NOP_INST = 32'h0000_0013;

    // ----------------------------------------
    // Instruction word views
    // ----------------------------------------
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic [19:0] imm20;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
    } inst_word_t;

endpackage

`default_nettype wire

/* hw/fetch_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_unit import cpu_pkg::*; (
    input  logic              cpuclk,
    input  logic              rst,
    input  logic              redirect,
    input  logic [DATA_W-1:0] redirect_pc,
    input  logic [DATA_W-1:0] fetch_inst,
    output logic [DATA_W-1:0] fetch_pc,
    output logic [DATA_W-1:0] dec_inst,
    output logic [DATA_W-1:0] dec_pc
);

    logic [DATA_W-1:0] pc;
    logic              slot_kill;

    // The memory registers the instruction itself, so the decode slot
    // only needs the PC and a kill flag that matches that word.
    always_ff @(posedge cpuclk) begin
        if (rst) begin
            pc        <= '0;
            slot_kill <= 1'b1;
        end else begin
            slot_kill <= redirect;
            if (redirect) begin
                pc <= redirect_pc;
            end else begin
                pc <= pc + 32'd4;
            end
        end
    end

    always_ff @(posedge cpuclk) begin
        dec_pc <= pc;
    end

    assign fetch_pc = pc;

    // A killed slot shows a NOP instead of the word fetched down the wrong path.
    assign dec_inst = slot_kill ? NOP_INST : fetch_inst;

endmodule

`default_nettype wire

/* hw/inst_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module inst_decoder import cpu_pkg::*; (
    input  logic [DATA_W-1:0]     dec_inst,
    output logic [REG_ADDR_W-1:0] rs1,
    output logic [REG_ADDR_W-1:0] rs2,
    output logic [REG_ADDR_W-1:0] rd,
    output logic [DATA_W-1:0]     imm,
    output logic [ALU_OP_W-1:0]   alu_op,
    output logic                  alu_src_imm,
    output logic                  reg_we,
    output logic                  mem_we,
    output logic                  mem_re,
    output logic [1:0]            wb_sel,
    output logic                  is_branch,
    output logic                  branch_ne,
    output logic                  is_jal
);

    inst_word_t        iw;
    logic [DATA_W-1:0] imm_i;
    logic [DATA_W-1:0] imm_s;
    logic [DATA_W-1:0] imm_b;
    logic [DATA_W-1:0] imm_u;
    logic [DATA_W-1:0] imm_j;

    assign iw  = dec_inst;
    assign rs1 = iw.r_fmt.rs1;
    assign rs2 = iw.r_fmt.rs2;
    assign rd  = iw.r_fmt.rd;

    // ----------------------------------------
    // Immediates
    // ----------------------------------------
    assign imm_i = {{20{iw.i_fmt.imm12[11]}}, iw.i_fmt.imm12};
    assign imm_s = {{20{iw.s_fmt.imm_hi[6]}}, iw.s_fmt.imm_hi, iw.s_fmt.imm_lo};
    assign imm_u = {iw.u_fmt.imm20, 12'b0};
    assign imm_b = {{19{iw.raw[31]}}, iw.raw[31], iw.raw[7], iw.raw[30:25],
                    iw.raw[11:8], 1'b0};
    assign imm_j = {{11{iw.raw[31]}}, iw.raw[31], iw.raw[19:12], iw.raw[20],
                    iw.raw[30:21], 1'b0};

    // ----------------------------------------
    // Control
    // ----------------------------------------
    always_comb begin
        imm         = imm_i;
        alu_op      = ALU_ADD;
        alu_src_imm = 1'b0;
        reg_we      = 1'b0;
        mem_we      = 1'b0;
        mem_re      = 1'b0;
        wb_sel      = WB_ALU;
        is_branch   = 1'b0;
        branch_ne   = 1'b0;
        is_jal      = 1'b0;
        case (iw.r_fmt.opcode)
            OP_R: begin
                reg_we = 1'b1;
                case (iw.r_fmt.funct3)
                    3'b000: alu_op = iw.r_fmt.funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b001: alu_op = ALU_SLL;
                    3'b010: alu_op = ALU_SLT;
                    3'b100: alu_op = ALU_XOR;
                    3'b101: alu_op = ALU_SRL;
                    3'b110: alu_op = ALU_OR;
                    3'b111: alu_op = ALU_AND;
                    default: reg_we = 1'b0;
                endcase
            end
            OP_I: begin
                alu_src_imm = 1'b1;
                reg_we      = 1'b1;
                case (iw.i_fmt.funct3)
                    3'b000: alu_op = ALU_ADD;
                    3'b010: alu_op = ALU_SLT;
                    3'b100: alu_op = ALU_XOR;
                    3'b110: alu_op = ALU_OR;
                    3'b111: alu_op = ALU_AND;
                    default: reg_we = 1'b0;
                endcase
            end
            OP_LOAD: begin
                alu_src_imm = 1'b1;
                if (iw.i_fmt.funct3 == 3'b010) begin
                    reg_we = 1'b1;
                    mem_re = 1'b1;
                    wb_sel = WB_MEM;
                end
            end
            OP_STORE: begin
                imm         = imm_s;
                alu_src_imm = 1'b1;
                mem_we      = (iw.s_fmt.funct3 == 3'b010);
            end
            OP_BRANCH: begin
                imm       = imm_b;
                alu_op    = ALU_SUB;
                is_branch = (iw.r_fmt.funct3[2:1] == 2'b00);
                branch_ne = iw.r_fmt.funct3[0];
            end
            OP_LUI: begin
                imm         = imm_u;
                alu_op      = ALU_PASS_B;
                alu_src_imm = 1'b1;
                reg_we      = 1'b1;
            end
            OP_JAL: begin
                imm    = imm_j;
                reg_we = 1'b1;
                wb_sel = WB_PC4;
                is_jal = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hw/reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  logic                  cpuclk,
    input  logic                  rst,
    input  logic [REG_ADDR_W-1:0] rs1,
    input  logic [REG_ADDR_W-1:0] rs2,
    input  logic                  wb_we,
    input  logic [REG_ADDR_W-1:0] wb_rd,
    input  logic [DATA_W-1:0]     wb_data,
    output logic [DATA_W-1:0]     rs1_data,
    output logic [DATA_W-1:0]     rs2_data
);

    logic [DATA_W-1:0] regs [0:(1<<REG_ADDR_W)-1];

    // x0 is cleared with the rest and never written, so it reads as zero.
    always_ff @(posedge cpuclk) begin
        if (rst) begin
            for (int i = 0; i < (1 << REG_ADDR_W); i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && (wb_rd != '0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Reads see the value from before a write in the same cycle.
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

`default_nettype wire

/* hw/exec_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_unit import cpu_pkg::*; (
    input  logic [DATA_W-1:0]     dec_pc,
    input  logic [DATA_W-1:0]     rs1_data,
    input  logic [DATA_W-1:0]     rs2_data,
    input  logic [DATA_W-1:0]     imm,
    input  logic [REG_ADDR_W-1:0] rd,
    input  logic [ALU_OP_W-1:0]   alu_op,
    input  logic                  alu_src_imm,
    input  logic                  reg_we,
    input  logic                  mem_we,
    input  logic                  mem_re,
    input  logic [1:0]            wb_sel,
    input  logic                  is_branch,
    input  logic                  branch_ne,
    input  logic                  is_jal,
    input  logic [DATA_W-1:0]     load_data,
    output logic                  redirect,
    output logic [DATA_W-1:0]     redirect_pc,
    output logic [DATA_W-1:0]     data_addr,
    output logic [DATA_W-1:0]     store_data,
    output logic                  store_we,
    output logic                  wb_we,
    output logic [REG_ADDR_W-1:0] wb_rd,
    output logic [DATA_W-1:0]     wb_data
);

    logic [DATA_W-1:0] operand_b;
    logic [DATA_W-1:0] alu_result;
    logic [DATA_W-1:0] pc_plus4;
    logic              operands_equal;
    logic              branch_taken;

    // ----------------------------------------
    // ALU
    // ----------------------------------------
    assign operand_b = alu_src_imm ? imm : rs2_data;

    always_comb begin
        case (alu_op)
            ALU_ADD:    alu_result = rs1_data + operand_b;
            ALU_SUB:    alu_result = rs1_data - operand_b;
            ALU_AND:    alu_result = rs1_data & operand_b;
            ALU_OR:     alu_result = rs1_data | operand_b;
            ALU_XOR:    alu_result = rs1_data ^ operand_b;
            ALU_SLT:    alu_result = {31'b0, $signed(rs1_data) < $signed(operand_b)};
            ALU_SLL:    alu_result = rs1_data << operand_b[4:0];
            ALU_SRL:    alu_result = rs1_data >> operand_b[4:0];
            ALU_PASS_B: alu_result = operand_b;
            default:    alu_result = '0;
        endcase
    end

    // ----------------------------------------
    // Next PC
    // ----------------------------------------
    assign operands_equal = (rs1_data == rs2_data);
    assign branch_taken   = is_branch && (operands_equal != branch_ne);
    assign redirect       = branch_taken || is_jal;
    assign redirect_pc    = dec_pc + imm;
    assign pc_plus4       = dec_pc + 32'd4;

    // The address bus stays at zero unless a load or store is in execute.
    assign data_addr  = (mem_re || mem_we) ? alu_result : '0;
    assign store_data = rs2_data;
    assign store_we   = mem_we;

    assign wb_we = reg_we;
    assign wb_rd = rd;

    always_comb begin
        case (wb_sel)
            WB_MEM:  wb_data = load_data;
            WB_PC4:  wb_data = pc_plus4;
            default: wb_data = alu_result;
        endcase
    end

endmodule

`default_nettype wire

/* hw/memory.sv */
`timescale 1ns/10ps
`default_nettype none

module memory import cpu_pkg::*; (
    input  logic              cpuclk,
    input  logic              rst,
    input  logic              uart_finish,
    input  logic [DATA_W-1:0] uart_addr,
    input  logic [DATA_W-1:0] uart_data,
    input  logic [DATA_W-1:0] fetch_pc,
    output logic [DATA_W-1:0] fetch_inst,
    input  logic [DATA_W-1:0] data_addr,
    input  logic [DATA_W-1:0] store_data,
    input  logic              store_we,
    output logic [DATA_W-1:0] load_data,
    input  logic [7:0]        switches,
    output logic [DATA_W-1:0] led_out
);

    logic [DATA_W-1:0]     mem_array [0:(1<<MEM_ADDR_W)-1];
    logic [DATA_W-1:0]     port_addr;
    logic [DATA_W-1:0]     port_data;
    logic                  port_we;
    logic                  sw_hit;
    logic                  led_hit;
    logic [MEM_ADDR_W-1:0] port_idx;
    logic [MEM_ADDR_W-1:0] fetch_idx;

    // Port B belongs to the loader until it raises uart_finish.
    assign port_addr = uart_finish ? data_addr : uart_addr;
    assign port_data = uart_finish ? store_data : uart_data;
    assign port_we   = uart_finish ? store_we : 1'b1;

    assign sw_hit    = (port_addr == SW_ADDR);
    assign led_hit   = (port_addr == LED_ADDR);
    assign port_idx  = port_addr[MEM_ADDR_W+1:2];
    assign fetch_idx = fetch_pc[MEM_ADDR_W+1:2];

    always_ff @(posedge cpuclk) begin
        fetch_inst <= mem_array[fetch_idx];
        if (port_we && !sw_hit && !led_hit) begin
            mem_array[port_idx] <= port_data;
        end
    end

    // Only the board reset clears the LEDs, not the core reset held during loading.
    always_ff @(posedge cpuclk) begin
        if (rst) begin
            led_out <= '0;
        end else if (port_we && led_hit) begin
            led_out <= port_data;
        end
    end

    assign load_data = sw_hit ? {{(DATA_W-8){1'b0}}, switches} : mem_array[port_idx];

endmodule

`default_nettype wire

/* hw/cpu.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu import cpu_pkg::*; (
    input  logic              cpuclk,
    input  logic              rst,
    input  logic [DATA_W-1:0] uart_data,
    input  logic [DATA_W-1:0] uart_addr,
    input  logic              uart_finish,
    input  logic [7:0]        switches,
    output logic [DATA_W-1:0] led_out,
    output logic [DATA_W-1:0] pc_t,
    output logic [DATA_W-1:0] inst_t,
    output logic [DATA_W-1:0] wb_data_t
);

    logic                  core_rst;
    logic [DATA_W-1:0]     fetch_pc, fetch_inst, dec_inst, dec_pc;
    logic                  redirect;
    logic [DATA_W-1:0]     redirect_pc;
    logic [REG_ADDR_W-1:0] rs1, rs2, rd, wb_rd;
    logic [DATA_W-1:0]     imm, rs1_data, rs2_data;
    logic [ALU_OP_W-1:0]   alu_op;
    logic                  alu_src_imm, reg_we, mem_we, mem_re;
    logic [1:0]            wb_sel;
    logic                  is_branch, branch_ne, is_jal;
    logic [DATA_W-1:0]     data_addr, store_data, load_data, wb_data;
    logic                  store_we, wb_we;

    // The core stays in reset while the loader fills memory.
    assign core_rst = rst | ~uart_finish;

    fetch_unit fetch_inst_u (
        .cpuclk,
        .rst(core_rst),
        .redirect,
        .redirect_pc,
        .fetch_inst,
        .fetch_pc,
        .dec_inst,
        .dec_pc
    );

    // ----------------------------------------
    // Decode and register read side by side
    // ----------------------------------------
    inst_decoder decoder_u (
        .dec_inst,
        .rs1,
        .rs2,
        .rd,
        .imm,
        .alu_op,
        .alu_src_imm,
        .reg_we,
        .mem_we,
        .mem_re,
        .wb_sel,
        .is_branch,
        .branch_ne,
        .is_jal
    );

    reg_file regs_u (
        .cpuclk,
        .rst(core_rst),
        .rs1,
        .rs2,
        .wb_we,
        .wb_rd,
        .wb_data,
        .rs1_data,
        .rs2_data
    );

    exec_unit exec_u (
        .dec_pc,
        .rs1_data,
        .rs2_data,
        .imm,
        .rd,
        .alu_op,
        .alu_src_imm,
        .reg_we,
        .mem_we,
        .mem_re,
        .wb_sel,
        .is_branch,
        .branch_ne,
        .is_jal,
        .load_data,
        .redirect,
        .redirect_pc,
        .data_addr,
        .store_data,
        .store_we,
        .wb_we,
        .wb_rd,
        .wb_data
    );

    memory memory_u (
        .cpuclk,
        .rst,
        .uart_finish,
        .uart_addr,
        .uart_data,
        .fetch_pc,
        .fetch_inst,
        .data_addr,
        .store_data,
        .store_we,
        .load_data,
        .switches,
        .led_out
    );

    // Debug taps.
    assign pc_t      = fetch_pc;
    assign inst_t    = dec_inst;
    assign wb_data_t = wb_data;

endmodule

`default_nettype wire

/* verif/cpu_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_assertions import cpu_pkg::*; (
    input logic              cpuclk,
    input logic              rst,
    input logic              core_rst,
    input logic              uart_finish,
    input logic              redirect,
    input logic              store_we,
    input logic [DATA_W-1:0] fetch_pc,
    input logic [DATA_W-1:0] dec_inst,
    input logic [DATA_W-1:0] data_addr,
    input logic [DATA_W-1:0] uart_addr,
    input logic [DATA_W-1:0] led_out
);

    logic led_write;

    // The loader owns the LED register address while uart_finish is low.
    assign led_write = uart_finish ? (store_we && (data_addr == LED_ADDR))
                                   : (uart_addr == LED_ADDR);

    pc_aligned: assert property (@(posedge cpuclk) disable iff (core_rst)
        fetch_pc[1:0] == 2'b00)
        else $error("fetch_pc is not word aligned");

    flush_shows_nop: assert property (@(posedge cpuclk) disable iff (core_rst)
        redirect |=> (dec_inst == NOP_INST))
        else $error("decode slot not flushed after redirect");

    led_only_on_store: assert property (@(posedge cpuclk) disable iff (rst)
        (led_out != $past(led_out)) |-> ($past(led_write) || $past(rst)))
        else $error("led_out changed without a store to the LED register");

endmodule

bind cpu cpu_assertions assertions_u (
    .cpuclk(cpuclk),
    .rst(rst),
    .core_rst(core_rst),
    .uart_finish(uart_finish),
    .redirect(redirect),
    .store_we(store_we),
    .fetch_pc(fetch_pc),
    .dec_inst(dec_inst),
    .data_addr(data_addr),
    .uart_addr(uart_addr),
    .led_out(led_out)
);

`default_nettype wire

/* verif/cpu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

    logic              cpuclk;
    logic              rst;
    logic [DATA_W-1:0] uart_data;
    logic [DATA_W-1:0] uart_addr;
    logic              uart_finish;
    logic [7:0]        switches;
    logic [DATA_W-1:0] led_out;
    logic [DATA_W-1:0] pc_t;
    logic [DATA_W-1:0] inst_t;
    logic [DATA_W-1:0] wb_data_t;

    string             test_name [$];
    logic [7:0]        test_sw [$];
    int                test_budget [$];
    logic [DATA_W-1:0] test_led [$];
    int                test_nwords [$];
    int                test_nexp [$];
    logic [DATA_W-1:0] word_addr [$];
    logic [DATA_W-1:0] word_data [$];
    logic [DATA_W-1:0] exp_wb [$];

    logic [DATA_W-1:0] rand_state = 32'd72;
    int                errors = 0;
    int                tests_failed = 0;
    int                cycle_count = 0;
    int                cycle_limit = 1 << 30;

    cpu uut (
        .cpuclk(cpuclk),
        .rst(rst),
        .uart_data(uart_data),
        .uart_addr(uart_addr),
        .uart_finish(uart_finish),
        .switches(switches),
        .led_out(led_out),
        .pc_t(pc_t),
        .inst_t(inst_t),
        .wb_data_t(wb_data_t)
    );

    initial begin
        cpuclk = 1'b0;
        forever #10 cpuclk = ~cpuclk;
    end

    always @(posedge cpuclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Run stopped after %0d cycles without finishing", cycle_count);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic logic [DATA_W-1:0] next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    task automatic check_word(input string what, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("FAILED t=%0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_led(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("FAILED t=%0t: led_out is %h, expected %h", $time, got, exp);
            errors++;
        end
    endtask

    // Each record kind carries a fixed number of fields.
    task automatic flag_short_record(input int got, input int want, input string line);
        if (got != want) begin
            $display("Test data record could not be read: %s", line);
            errors++;
        end
    endtask

    // ----------------------------------------
    // Test data file
    // ----------------------------------------
    task automatic read_test_data();
        int                fd;
        int                n;
        int                total;
        string             line;
        string             name;
        logic [7:0]        sw;
        int                budget;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] d;
        total = 0;
        fd = $fopen("verif/cpu_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open verif/cpu_testdata.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() > 0) begin
                    case (line.getc(0))
                        8'h54: begin
                            n = $sscanf(line, "T %s %h %d %h", name, sw, budget, d);
                            flag_short_record(n, 4, line);
                            test_name.push_back(name);
                            test_sw.push_back(sw);
                            test_budget.push_back(budget);
                            test_led.push_back(d);
                            test_nwords.push_back(0);
                            test_nexp.push_back(0);
                            total += budget + 4;
                        end
                        8'h57: begin
                            n = $sscanf(line, "W %h %h", a, d);
                            flag_short_record(n, 2, line);
                            word_addr.push_back(a);
                            word_data.push_back(d);
                            test_nwords[test_nwords.size()-1]++;
                            total++;
                        end
                        8'h45: begin
                            n = $sscanf(line, "E %h", d);
                            flag_short_record(n, 1, line);
                            exp_wb.push_back(d);
                            test_nexp[test_nexp.size()-1]++;
                        end
                        default: ;
                    endcase
                end
            end
            $fclose(fd);
        end
        cycle_limit = 16 + (1 << MEM_ADDR_W) + total + 200;
    endtask

    // One loader cycle, with the idle checks on the core held in reset.
    task automatic load_word(input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] d);
        @(posedge cpuclk);
        #2;
        uart_addr = a;
        uart_data = d;
        @(negedge cpuclk);
        check_word("pc_t while loading", pc_t, '0);
        check_word("inst_t while loading", inst_t, NOP_INST);
    endtask

    initial begin
        int wi;
        int ei;
        int seen;
        int start_errors;
        rst = 1'b1;
        uart_finish = 1'b0;
        uart_addr = '0;
        uart_data = '0;
        switches = '0;
        wi = 0;
        ei = 0;
        read_test_data();
        repeat (16) @(posedge cpuclk);
        #2;
        rst = 1'b0;

        // Fill the whole memory with random words first.
        start_errors = errors;
        for (int i = 0; i < (1 << MEM_ADDR_W); i++) begin
            load_word(i * 4, next_rand());
            check_led(led_out, '0);
        end
        if (errors == start_errors) begin
            $display("test load_idle: ok");
        end else begin
            $display("test load_idle: %0d errors", errors - start_errors);
            tests_failed++;
        end

        for (int t = 0; t < test_name.size(); t++) begin
            start_errors = errors;
            for (int w = 0; w < test_nwords[t]; w++) begin
                load_word(word_addr[wi], word_data[wi]);
                wi++;
            end
            @(posedge cpuclk);
            #2;
            switches = test_sw[t];
            uart_finish = 1'b1;
            seen = 0;
            for (int c = 0; c < test_budget[t]; c++) begin
                @(negedge cpuclk);
                if (inst_t != NOP_INST && seen < test_nexp[t]) begin
                    check_word("wb_data_t", wb_data_t, exp_wb[ei + seen]);
                    seen++;
                end
            end
            if (seen < test_nexp[t]) begin
                $display("Test %s executed only %0d of %0d expected instructions",
                         test_name[t], seen, test_nexp[t]);
                errors++;
            end
            ei += test_nexp[t];
            check_led(led_out, test_led[t]);
            @(posedge cpuclk);
            #2;
            uart_finish = 1'b0;
            if (errors == start_errors) begin
                $display("test %s: ok", test_name[t]);
            end else begin
                $display("test %s: %0d errors", test_name[t], errors - start_errors);
                tests_failed++;
            end
        end

        $display("%0d tests run, %0d failed, %0d errors",
                 test_name.size() + 1, tests_failed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/cpu_testdata.txt */
# T name switches(hex) cycle_budget(dec) expected_led(hex) | W byte_addr word | E writeback
# E records list wb_data_t of the first executed instructions in order; X ends a test.
T alu_ops 00 40 00000047
W 00000000 00500093
W 00000004 00300113
W 00000008 002081B3
W 0000000C 40208233
W 00000010 002092B3
W 00000014 0041C333
W 00000018 001223B3
W 0000001C 07036413
W 00000020 00F47493
W 00000024 00745533
W 00000028 009505B3
W 0000002C FFF5C693
W 00000030 0006A713
W 00000034 00001637
W 00000038 00B62223
W 0000003C 0000006F
E 00000005
E 00000003
E 00000008
E 00000002
E 00000028
E 0000000A
E 00000001
E 0000007A
E 0000000A
E 0000003D
E 00000047
E FFFFFFB8
E 00000001
E 00001000
E 00001004
X
T countdown 00 60 0000000F
W 00000000 00500093
W 00000004 00000113
W 00000008 FFF00193
W 0000000C 00110133
W 00000010 003080B3
W 00000014 FE009CE3
W 00000018 00C0006F
W 0000001C 06410113
W 00000020 06410113
W 00000024 00001237
W 00000028 00222223
W 0000002C 0000006F
E 00000005
E 00000000
E FFFFFFFF
E 00000005
E 00000004
X
T mem_rw 00 30 12345678
W 00000000 123450B7
W 00000004 67808093
W 00000008 20000113
W 0000000C 00112023
W 00000010 00012183
W 00000014 00001237
W 00000018 00322223
W 0000001C 0000006F
E 12345000
E 12345678
E 00000200
E 00000200
E 12345678
E 00001000
X
T switch_read A5 30 000000A5
W 00000000 000010B7
W 00000004 008002EF
W 00000008 05500113
W 0000000C 0000A103
W 00000010 0020A223
W 00000014 0000006F
E 00001000
E 00000008
E 000000A5
X

/* cpu.f */
hw/cpu_pkg.sv
hw/fetch_unit.sv
hw/inst_decoder.sv
hw/reg_file.sv
hw/exec_unit.sv
hw/memory.sv
hw/cpu.sv
verif/cpu_assertions.sv
verif/cpu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the cpu testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module cpu_tb \
    -f cpu.f \
    -o cpu_sim

./obj_dir/cpu_sim | tee sim.log

if grep -q "Testbench passed" sim.log; then
    echo "Simulation result: pass"
else
    echo "Simulation result: fail"
    exit 1
fi
